// File: logic/daq_consts.svh
`ifndef DAQ_CONSTS_SVH
`define DAQ_CONSTS_SVH

// Local bus widths
`define DAQ_ABUS_WIDTH      32
`define DAQ_DBUS_WIDTH      8

// Address map of the register blocks
`define DAQ_SYS_BASE        32'h0000_0300
`define DAQ_SYS_HIGH        32'h0000_03FF
`define DAQ_CTRL_BASE       32'h0000_0500
`define DAQ_CTRL_HIGH       32'h0000_05FF

// Read-only firmware identification
`define DAQ_VERSION         8'd1
`define DAQ_VERSION_MINOR   8'd0
`define DAQ_VERSION_MAJOR   8'd0

// Data stream
`define DAQ_N_SOURCES       6
`define DAQ_STREAM_WIDTH    32

`endif

// File: logic/daq_bus_pkg.sv
package daq_bus_pkg;

    // Board identifiers, as read back from the system block
    typedef enum logic [7:0] {
        SIM    = 8'd0,
        BDAQ53 = 8'd1,
        MIO3   = 8'd2
    } board_e;

    // System block register offsets
    typedef enum logic [7:0] {
        VERSION     = 8'd0,
        MINOR       = 8'd1,
        MAJOR       = 8'd2,
        BOARD       = 8'd3,
        CFG_FLAG_RD = 8'd4,
        CFG_FLAG_WR = 8'd5
    } sys_reg_e;

    // Decoded bus targets
    typedef enum logic [1:0] {SEL_NONE, SEL_SYS, SEL_CTRL} bus_sel_e;

endpackage

// File: logic/daq_stream_pkg.sv
package daq_stream_pkg;

    // Index of one stream source
    typedef logic [2:0] src_idx_t;

    // Arbiter mode
    // ARB_HOLD keeps the current owner, ARB_ROUND searches onward
    typedef enum logic {
        ARB_ROUND = 1'b0,
        ARB_HOLD  = 1'b1
    } arb_state_e;

endpackage

// File: logic/bus_decoder.sv
`timescale 1ns/10ps
`include "daq_consts.svh"

module bus_decoder (
    input  logic                        BUS_CLK,
    input  logic                        BUS_RST,
    input  logic [`DAQ_ABUS_WIDTH-1:0]  i_bus_addr,
    input  logic                        i_bus_rd,
    input  logic                        i_bus_wr,
    output logic                        o_sys_rd,
    output logic                        o_sys_wr,
    output logic                        o_ctrl_rd,
    output logic                        o_ctrl_wr,
    output logic [7:0]                  o_offset,
    input  logic [`DAQ_DBUS_WIDTH-1:0]  i_sys_rdata,
    input  logic [`DAQ_DBUS_WIDTH-1:0]  i_ctrl_rdata,
    output logic [`DAQ_DBUS_WIDTH-1:0]  o_bus_rdata
);

    daq_bus_pkg::bus_sel_e      addr_sel;
    daq_bus_pkg::bus_sel_e      rd_sel_q;
    logic [`DAQ_ABUS_WIDTH-1:0] local_addr;

    // Range match and local offset
    always_comb begin
        if (i_bus_addr >= `DAQ_SYS_BASE && i_bus_addr <= `DAQ_SYS_HIGH) begin
            addr_sel   = daq_bus_pkg::SEL_SYS;
            local_addr = i_bus_addr - `DAQ_SYS_BASE;
        end else if (i_bus_addr >= `DAQ_CTRL_BASE && i_bus_addr <= `DAQ_CTRL_HIGH) begin
            addr_sel   = daq_bus_pkg::SEL_CTRL;
            local_addr = i_bus_addr - `DAQ_CTRL_BASE;
        end else begin
            addr_sel   = daq_bus_pkg::SEL_NONE;
            local_addr = '0;
        end
    end

    assign o_offset  = local_addr[7:0];
    assign o_sys_rd  = i_bus_rd && (addr_sel == daq_bus_pkg::SEL_SYS);
    assign o_sys_wr  = i_bus_wr && (addr_sel == daq_bus_pkg::SEL_SYS);
    assign o_ctrl_rd = i_bus_rd && (addr_sel == daq_bus_pkg::SEL_CTRL);
    assign o_ctrl_wr = i_bus_wr && (addr_sel == daq_bus_pkg::SEL_CTRL);

    // Remember the target of the last read
    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            rd_sel_q <= daq_bus_pkg::SEL_NONE;
        end else if (i_bus_rd) begin
            rd_sel_q <= addr_sel;
        end
    end

    always_comb begin
        case (rd_sel_q)
            daq_bus_pkg::SEL_SYS:  o_bus_rdata = i_sys_rdata;
            daq_bus_pkg::SEL_CTRL: o_bus_rdata = i_ctrl_rdata;
            default:               o_bus_rdata = '0;
        endcase
    end

endmodule

// File: logic/system_regs.sv
`timescale 1ns/10ps
`include "daq_consts.svh"

module system_regs #(
    parameter daq_bus_pkg::board_e BOARD_ID = daq_bus_pkg::SIM
) (
    input  logic                        BUS_CLK,
    input  logic                        BUS_RST,
    input  logic                        i_rd,
    input  logic                        i_wr,
    input  logic [7:0]                  i_offset,
    input  logic [`DAQ_DBUS_WIDTH-1:0]  i_wdata,
    output logic [`DAQ_DBUS_WIDTH-1:0]  o_rdata
);

    daq_bus_pkg::sys_reg_e          reg_sel;
    logic [`DAQ_DBUS_WIDTH-1:0]     rd_byte;
    logic                           cfg_flag;

    assign reg_sel = daq_bus_pkg::sys_reg_e'(i_offset);

    // Clock configured flag, set by software
    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            cfg_flag <= 1'b0;
        end else if (i_wr && reg_sel == daq_bus_pkg::CFG_FLAG_WR) begin
            cfg_flag <= i_wdata[0];
        end
    end

    always_comb begin
        case (reg_sel)
            daq_bus_pkg::VERSION:     rd_byte = `DAQ_VERSION;
            daq_bus_pkg::MINOR:       rd_byte = `DAQ_VERSION_MINOR;
            daq_bus_pkg::MAJOR:       rd_byte = `DAQ_VERSION_MAJOR;
            daq_bus_pkg::BOARD:       rd_byte = BOARD_ID;
            daq_bus_pkg::CFG_FLAG_RD: rd_byte = {{(`DAQ_DBUS_WIDTH-1){1'b0}}, cfg_flag};
            default:                  rd_byte = '0;
        endcase
    end

    // Read byte held until the next read of this block
    always_ff @(posedge BUS_CLK) begin
        if (i_rd) begin
            o_rdata <= rd_byte;
        end
    end

endmodule

// File: logic/control_gpio.sv
`timescale 1ns/10ps
`include "daq_consts.svh"

module control_gpio (
    input  logic                        BUS_CLK,
    input  logic                        BUS_RST,
    input  logic                        i_rd,
    input  logic                        i_wr,
    input  logic [7:0]                  i_offset,
    input  logic [`DAQ_DBUS_WIDTH-1:0]  i_wdata,
    output logic [`DAQ_DBUS_WIDTH-1:0]  o_rdata,
    input  logic [3:0]                  i_gpio_sense,
    output logic                        o_mgt_ref_sel,
    output logic [7:0]                  o_lemo_mux,
    output logic [2:0]                  o_ntc_mux
);

    // Only the writable bits are stored
    logic [15:4]                    ctrl_q;
    logic [15:0]                    io_ctrl;
    logic [`DAQ_DBUS_WIDTH-1:0]     rd_byte;

    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            ctrl_q <= '0;
        end else if (i_wr) begin
            case (i_offset)
                8'd0:    ctrl_q[7:4]  <= i_wdata[7:4];
                8'd1:    ctrl_q[15:8] <= i_wdata;
                default: ctrl_q       <= ctrl_q;
            endcase
        end
    end

    // Sense lines fill the low nibble
    assign io_ctrl = {ctrl_q, i_gpio_sense};

    always_comb begin
        case (i_offset)
            8'd0:    rd_byte = io_ctrl[7:0];
            8'd1:    rd_byte = io_ctrl[15:8];
            default: rd_byte = '0;
        endcase
    end

    always_ff @(posedge BUS_CLK) begin
        if (i_rd) begin
            o_rdata <= rd_byte;
        end
    end

    // Bit 15 cleared selects the internal reference clock
    assign o_mgt_ref_sel = ~io_ctrl[15];
    assign o_lemo_mux    = io_ctrl[14:7];
    assign o_ntc_mux     = io_ctrl[6:4];

endmodule

// File: logic/rrp_arbiter.sv
`timescale 1ns/10ps
`include "daq_consts.svh"

module rrp_arbiter (
    input  logic                                            BUS_CLK,
    input  logic                                            BUS_RST,
    input  logic [`DAQ_N_SOURCES-1:0]                       i_req_empty,
    input  logic [`DAQ_N_SOURCES-1:0]                       i_hold,
    input  logic [`DAQ_N_SOURCES-1:0][`DAQ_STREAM_WIDTH-1:0] i_data,
    output logic [`DAQ_N_SOURCES-1:0]                       o_read,
    input  logic                                            i_ready,
    output logic                                            o_write,
    output logic [`DAQ_STREAM_WIDTH-1:0]                    o_data
);

    daq_stream_pkg::src_idx_t   last_q;
    daq_stream_pkg::src_idx_t   rr_idx;
    daq_stream_pkg::src_idx_t   grant_idx;
    daq_stream_pkg::arb_state_e state;
    logic                       found;
    int                         cand;

    // Owner keeps the grant while it holds and still has data
    always_comb begin
        if (i_hold[last_q] && !i_req_empty[last_q]) begin
            state = daq_stream_pkg::ARB_HOLD;
        end else begin
            state = daq_stream_pkg::ARB_ROUND;
        end
    end

    // First non-empty source after the last grant, wrapping around
    always_comb begin
        found  = 1'b0;
        rr_idx = last_q;
        cand   = 0;
        for (int i = 1; i <= `DAQ_N_SOURCES; i++) begin
            cand = (int'(last_q) + i) % `DAQ_N_SOURCES;
            if (!found && !i_req_empty[cand]) begin
                found  = 1'b1;
                rr_idx = daq_stream_pkg::src_idx_t'(cand);
            end
        end
    end

    assign grant_idx = (state == daq_stream_pkg::ARB_HOLD) ? last_q : rr_idx;

    // Zero latency grant, only while the sink is ready
    assign o_write = i_ready && found;
    assign o_data  = i_data[grant_idx];

    always_comb begin
        o_read = '0;
        if (o_write) begin
            o_read[grant_idx] = 1'b1;
        end
    end

    // Pointer starts at the top so that the first search begins at 0
    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            last_q <= daq_stream_pkg::src_idx_t'(`DAQ_N_SOURCES - 1);
        end else if (o_write) begin
            last_q <= grant_idx;
        end
    end

endmodule

// File: logic/daq_core.sv
`timescale 1ns/10ps
`include "daq_consts.svh"

module daq_core (
    input  logic                                            BUS_CLK,
    input  logic                                            BUS_RST,
    input  logic [`DAQ_ABUS_WIDTH-1:0]                      i_bus_addr,
    input  logic [`DAQ_DBUS_WIDTH-1:0]                      i_bus_wdata,
    input  logic                                            i_bus_rd,
    input  logic                                            i_bus_wr,
    output logic [`DAQ_DBUS_WIDTH-1:0]                      o_bus_rdata,
    input  logic [3:0]                                      i_gpio_sense,
    output logic                                            o_mgt_ref_sel,
    output logic [7:0]                                      o_lemo_mux,
    output logic [2:0]                                      o_ntc_mux,
    input  logic [`DAQ_N_SOURCES-1:0]                       i_src_empty,
    input  logic [`DAQ_N_SOURCES-1:0]                       i_src_hold,
    input  logic [`DAQ_N_SOURCES-1:0][`DAQ_STREAM_WIDTH-1:0] i_src_data,
    output logic [`DAQ_N_SOURCES-1:0]                       o_src_read,
    input  logic                                            i_arb_ready,
    output logic                                            o_arb_write,
    output logic [`DAQ_STREAM_WIDTH-1:0]                    o_arb_data
);

    logic                       sys_rd;
    logic                       sys_wr;
    logic                       ctrl_rd;
    logic                       ctrl_wr;
    logic [7:0]                 offset;
    logic [`DAQ_DBUS_WIDTH-1:0] sys_rdata;
    logic [`DAQ_DBUS_WIDTH-1:0] ctrl_rdata;

    bus_decoder u_bus_decoder (
        .BUS_CLK      (BUS_CLK),
        .BUS_RST      (BUS_RST),
        .i_bus_addr   (i_bus_addr),
        .i_bus_rd     (i_bus_rd),
        .i_bus_wr     (i_bus_wr),
        .o_sys_rd     (sys_rd),
        .o_sys_wr     (sys_wr),
        .o_ctrl_rd    (ctrl_rd),
        .o_ctrl_wr    (ctrl_wr),
        .o_offset     (offset),
        .i_sys_rdata  (sys_rdata),
        .i_ctrl_rdata (ctrl_rdata),
        .o_bus_rdata  (o_bus_rdata)
    );

    system_regs #(
        .BOARD_ID (daq_bus_pkg::SIM)
    ) u_system_regs (
        .BUS_CLK  (BUS_CLK),
        .BUS_RST  (BUS_RST),
        .i_rd     (sys_rd),
        .i_wr     (sys_wr),
        .i_offset (offset),
        .i_wdata  (i_bus_wdata),
        .o_rdata  (sys_rdata)
    );

    // Base-board control lines
    control_gpio u_control_gpio (
        .BUS_CLK       (BUS_CLK),
        .BUS_RST       (BUS_RST),
        .i_rd          (ctrl_rd),
        .i_wr          (ctrl_wr),
        .i_offset      (offset),
        .i_wdata       (i_bus_wdata),
        .o_rdata       (ctrl_rdata),
        .i_gpio_sense  (i_gpio_sense),
        .o_mgt_ref_sel (o_mgt_ref_sel),
        .o_lemo_mux    (o_lemo_mux),
        .o_ntc_mux     (o_ntc_mux)
    );

    rrp_arbiter u_rrp_arbiter (
        .BUS_CLK     (BUS_CLK),
        .BUS_RST     (BUS_RST),
        .i_req_empty (i_src_empty),
        .i_hold      (i_src_hold),
        .i_data      (i_src_data),
        .o_read      (o_src_read),
        .i_ready     (i_arb_ready),
        .o_write     (o_arb_write),
        .o_data      (o_arb_data)
    );

endmodule

// File: verif/daq_core_assertions.sv
`timescale 1ns/10ps
`include "daq_consts.svh"

module daq_core_assertions (
    input  logic                         BUS_CLK,
    input  logic                         BUS_RST,
    input  logic                         i_arb_ready,
    input  logic [`DAQ_N_SOURCES-1:0]    i_src_empty,
    input  logic [`DAQ_N_SOURCES-1:0]    i_src_read,
    input  logic                         i_arb_write,
    input  logic [`DAQ_DBUS_WIDTH-1:0]   i_bus_rdata,
    input  logic                         i_mgt_ref_sel,
    input  logic [7:0]                   i_lemo_mux,
    input  logic [2:0]                   i_ntc_mux
);

    int assert_errors = 0;

    write_needs_ready: assert property (@(posedge BUS_CLK) disable iff (BUS_RST)
        i_arb_write |-> i_arb_ready)
        else begin
            $error("Arbiter wrote a word while the sink was not ready");
            assert_errors++;
        end

    // One pop per written word
    write_pops_one: assert property (@(posedge BUS_CLK) disable iff (BUS_RST)
        i_arb_write |-> $onehot(i_src_read))
        else begin
            $error("Arbiter write without exactly one source read");
            assert_errors++;
        end

    no_write_no_pop: assert property (@(posedge BUS_CLK) disable iff (BUS_RST)
        !i_arb_write |-> (i_src_read == '0))
        else begin
            $error("Source read while the arbiter did not write");
            assert_errors++;
        end

    no_pop_of_empty: assert property (@(posedge BUS_CLK) disable iff (BUS_RST)
        (i_src_read & i_src_empty) == '0)
        else begin
            $error("Arbiter popped an empty source");
            assert_errors++;
        end

    reset_values: assert property (@(posedge BUS_CLK)
        BUS_RST |=> (i_bus_rdata == '0 && i_mgt_ref_sel && i_lemo_mux == '0 && i_ntc_mux == '0))
        else begin
            $error("Register outputs not at their reset values after reset");
            assert_errors++;
        end

endmodule

// File: verif/daq_core_checker.sv
`timescale 1ns/10ps
`include "daq_consts.svh"

module daq_core_checker (
    input  logic                            BUS_CLK,
    input  logic                            BUS_RST,
    input  int                              i_test_id,
    input  logic [`DAQ_ABUS_WIDTH-1:0]      i_bus_addr,
    input  logic [`DAQ_DBUS_WIDTH-1:0]      i_bus_wdata,
    input  logic                            i_bus_rd,
    input  logic                            i_bus_wr,
    input  logic [`DAQ_DBUS_WIDTH-1:0]      i_bus_rdata,
    input  logic [3:0]                      i_gpio_sense,
    input  logic                            i_mgt_ref_sel,
    input  logic [7:0]                      i_lemo_mux,
    input  logic [2:0]                      i_ntc_mux,
    input  logic [`DAQ_N_SOURCES-1:0]       i_src_empty,
    input  logic [`DAQ_N_SOURCES-1:0]       i_src_hold,
    input  logic [`DAQ_N_SOURCES-1:0]       i_src_read,
    input  logic                            i_arb_ready,
    input  logic                            i_arb_write,
    input  logic [`DAQ_STREAM_WIDTH-1:0]    i_arb_data,
    output int                              o_errors
);

    localparam int N = `DAQ_N_SOURCES;

    int          errors = 0;
    logic [15:0] ctrl_m;
    logic        flag_m;
    logic [7:0]  rd_exp;
    int          last_m;
    int          seq_m [N];
    string       test_names [7] = '{"idle", "sys_regs", "ctrl_regs", "unmapped",
                                    "rotation", "random_stream", "hold"};

    assign o_errors = errors;

    // Offset inside the block range, -1 outside
    function automatic int block_offset(input logic [31:0] addr, input logic [31:0] base,
                                        input logic [31:0] high);
        return (addr >= base && addr <= high) ? int'(addr - base) : -1;
    endfunction

    function automatic logic [7:0] expected_rdata(input logic [31:0] addr,
                                                  input logic [15:0] ctrl,
                                                  input logic flag, input logic [3:0] sense);
        int         sys_off;
        int         ctrl_off;
        logic [7:0] value;
        sys_off  = block_offset(addr, `DAQ_SYS_BASE, `DAQ_SYS_HIGH);
        ctrl_off = block_offset(addr, `DAQ_CTRL_BASE, `DAQ_CTRL_HIGH);
        value    = 8'd0;
        case (sys_off)
            0:       value = `DAQ_VERSION;
            1:       value = `DAQ_VERSION_MINOR;
            2:       value = `DAQ_VERSION_MAJOR;
            3:       value = 8'(daq_bus_pkg::SIM);
            4:       value = {7'd0, flag};
            default: value = 8'd0;
        endcase
        if (ctrl_off == 0) value = {ctrl[7:4], sense};
        if (ctrl_off == 1) value = ctrl[15:8];
        return value;
    endfunction

    // Held owner first, then upward search from last plus one
    function automatic int expected_grant(input logic [N-1:0] empty, input logic [N-1:0] hold,
                                          input int last);
        int grant;
        int cand;
        grant = -1;
        if (hold[last] && !empty[last]) grant = last;
        for (int i = 1; i <= N && grant < 0; i++) begin
            cand = (last + i) % N;
            if (!empty[cand]) grant = cand;
        end
        return grant;
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED [%s] %s: expected 0x%0h, actual 0x%0h at %0t",
                     test_names[i_test_id], what, expected, actual, $time);
            errors++;
        end
    endtask

    always @(posedge BUS_CLK) begin : reg_check
        int sys_off;
        int ctrl_off;
        sys_off  = block_offset(i_bus_addr, `DAQ_SYS_BASE, `DAQ_SYS_HIGH);
        ctrl_off = block_offset(i_bus_addr, `DAQ_CTRL_BASE, `DAQ_CTRL_HIGH);
        if (BUS_RST) begin
            ctrl_m <= '0;
            flag_m <= 1'b0;
            rd_exp <= '0;
        end else begin
            check_value("bus read data", rd_exp, i_bus_rdata);
            check_value("mgt_ref_sel", {31'd0, ~ctrl_m[15]}, i_mgt_ref_sel);
            check_value("lemo_mux", ctrl_m[14:7], i_lemo_mux);
            check_value("ntc_mux", ctrl_m[6:4], i_ntc_mux);
            if (i_bus_rd) rd_exp <= expected_rdata(i_bus_addr, ctrl_m, flag_m, i_gpio_sense);
            if (i_bus_wr && sys_off == 5) flag_m <= i_bus_wdata[0];
            if (i_bus_wr && ctrl_off == 0) ctrl_m[7:4] <= i_bus_wdata[7:4];
            if (i_bus_wr && ctrl_off == 1) ctrl_m[15:8] <= i_bus_wdata;
        end
    end

    // Words carry source index and per-source sequence number
    always @(posedge BUS_CLK) begin : stream_check
        int           grant;
        logic [N-1:0] exp_read;
        if (BUS_RST) begin
            last_m <= N - 1;
            for (int k = 0; k < N; k++) seq_m[k] <= 0;
        end else begin
            grant    = i_arb_ready ? expected_grant(i_src_empty, i_src_hold, last_m) : -1;
            exp_read = '0;
            if (grant >= 0) exp_read[grant] = 1'b1;
            check_value("source read", exp_read, i_src_read);
            check_value("arbiter write", {31'd0, grant >= 0}, i_arb_write);
            if (grant >= 0) begin
                check_value("arbiter data", {grant[7:0], seq_m[grant][23:0]}, i_arb_data);
                seq_m[grant] <= seq_m[grant] + 1;
                last_m       <= grant;
            end
        end
    end

endmodule

// File: verif/daq_core_tb.sv
`timescale 1ns/10ps
`include "daq_consts.svh"

module daq_core_tb;

    localparam int CLK_PERIOD    = 20;
    localparam int N             = `DAQ_N_SOURCES;
    // Cycle budget of all tests together
    localparam int TEST_CYCLES   = 40 + 120 + 60 + 60 + 1500 + 80 + 140;
    localparam int WATCHDOG_NS   = 4 * TEST_CYCLES * CLK_PERIOD;
    localparam int RANDOM_CYCLES = 1400;
    localparam int DRAIN_LIMIT   = 140;
    localparam logic [31:0] QUIET_ADDR [10] = '{
        32'h0000_0000, 32'h0000_02FF, 32'h0000_0400, 32'h0000_0600, 32'hFFFF_FFFF,
        `DAQ_CTRL_BASE + 2, `DAQ_CTRL_BASE + 32'hFF, `DAQ_SYS_BASE + 6,
        `DAQ_SYS_BASE + 32'h80, `DAQ_SYS_BASE + 32'hFF};

    logic                   BUS_CLK;
    logic                   BUS_RST;
    logic [31:0]            i_bus_addr;
    logic [7:0]             i_bus_wdata;
    logic                   i_bus_rd;
    logic                   i_bus_wr;
    logic [7:0]             o_bus_rdata;
    logic [3:0]             i_gpio_sense;
    logic                   o_mgt_ref_sel;
    logic [7:0]             o_lemo_mux;
    logic [2:0]             o_ntc_mux;
    logic [N-1:0]           i_src_empty;
    logic [N-1:0]           i_src_hold;
    logic [N-1:0][31:0]     i_src_data;
    logic [N-1:0]           o_src_read;
    logic                   i_arb_ready;
    logic                   o_arb_write;
    logic [31:0]            o_arb_data;
    integer                 seed;
    int                     test_id;
    int                     tb_errors;
    int                     chk_errors;
    logic [31:0]            src_q [N][$];
    int                     seq [N];

    daq_core u_dut (.*);

    daq_core_checker u_checker (
        .BUS_CLK       (BUS_CLK),
        .BUS_RST       (BUS_RST),
        .i_test_id     (test_id),
        .i_bus_addr    (i_bus_addr),
        .i_bus_wdata   (i_bus_wdata),
        .i_bus_rd      (i_bus_rd),
        .i_bus_wr      (i_bus_wr),
        .i_bus_rdata   (o_bus_rdata),
        .i_gpio_sense  (i_gpio_sense),
        .i_mgt_ref_sel (o_mgt_ref_sel),
        .i_lemo_mux    (o_lemo_mux),
        .i_ntc_mux     (o_ntc_mux),
        .i_src_empty   (i_src_empty),
        .i_src_hold    (i_src_hold),
        .i_src_read    (o_src_read),
        .i_arb_ready   (i_arb_ready),
        .i_arb_write   (o_arb_write),
        .i_arb_data    (o_arb_data),
        .o_errors      (chk_errors)
    );

    bind daq_core daq_core_assertions u_assertions (
        .BUS_CLK       (BUS_CLK),
        .BUS_RST       (BUS_RST),
        .i_arb_ready   (i_arb_ready),
        .i_src_empty   (i_src_empty),
        .i_src_read    (o_src_read),
        .i_arb_write   (o_arb_write),
        .i_bus_rdata   (o_bus_rdata),
        .i_mgt_ref_sel (o_mgt_ref_sel),
        .i_lemo_mux    (o_lemo_mux),
        .i_ntc_mux     (o_ntc_mux)
    );

    initial begin
        BUS_CLK = 1'b0;
        forever #(CLK_PERIOD / 2) BUS_CLK = ~BUS_CLK;
    end

    task automatic bus_write(input logic [31:0] addr, input logic [7:0] data);
        @(posedge BUS_CLK);
        i_bus_addr  <= addr;
        i_bus_wdata <= data;
        i_bus_wr    <= 1'b1;
        @(posedge BUS_CLK);
        i_bus_wr    <= 1'b0;
    endtask

    task automatic bus_read(input logic [31:0] addr);
        @(posedge BUS_CLK);
        i_bus_addr <= addr;
        i_bus_rd   <= 1'b1;
        @(posedge BUS_CLK);
        i_bus_rd   <= 1'b0;
    endtask

    task automatic push_words(input int k, input int count);
        for (int i = 0; i < count; i++) begin
            src_q[k].push_back({8'(k), 24'(seq[k])});
            seq[k]++;
        end
    endtask

    function automatic bit all_empty();
        bit empty;
        empty = 1'b1;
        for (int k = 0; k < N; k++) if (src_q[k].size() != 0) empty = 1'b0;
        return empty;
    endfunction

    // Queues are popped on the rising edge, so look at them on the falling one
    task automatic wait_drained(input int limit);
        int n;
        n = 0;
        while (!all_empty() && n < limit) begin
            @(negedge BUS_CLK);
            n++;
        end
        if (!all_empty()) begin
            $display("Source queues still hold words after %0d cycles in test %0d", limit, test_id);
            tb_errors++;
        end
        repeat (2) @(negedge BUS_CLK);
    endtask

    // FWFT sources, popped on the arbiter read grant
    initial begin : source_model
        i_src_empty = '1;
        i_src_data  = '0;
        forever begin
            @(posedge BUS_CLK);
            for (int k = 0; k < N; k++) begin
                if (o_src_read[k] && src_q[k].size() > 0) void'(src_q[k].pop_front());
                i_src_empty[k] <= (src_q[k].size() == 0);
                i_src_data[k]  <= (src_q[k].size() > 0) ? src_q[k][0] : 32'd0;
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the tests did not complete", WATCHDOG_NS);
        $display("Result: FAILED");
        $finish;
    end

    initial begin : stimulus
        seed         = 31;
        test_id      = 0;
        tb_errors    = 0;
        BUS_RST      = 1'b1;
        i_bus_addr   = '0;
        i_bus_wdata  = '0;
        i_bus_rd     = 1'b0;
        i_bus_wr     = 1'b0;
        i_gpio_sense = '0;
        i_src_hold   = '0;
        i_arb_ready  = 1'b0;
        for (int k = 0; k < N; k++) seq[k] = 0;
        repeat (3) @(posedge BUS_CLK);
        BUS_RST <= 1'b0;

        test_id <= 1;
        for (int off = 0; off < 5; off++) bus_read(`DAQ_SYS_BASE + off);
        bus_write(`DAQ_SYS_BASE + 5, 8'h01);
        bus_read(`DAQ_SYS_BASE + 4);
        bus_write(`DAQ_SYS_BASE + 5, 8'h00);
        bus_read(`DAQ_SYS_BASE + 4);

        test_id <= 2;
        repeat (4) @(posedge BUS_CLK);
        for (int i = 0; i < 12; i++) begin
            bus_write(`DAQ_CTRL_BASE + (i % 2), 8'($random(seed)));
            @(posedge BUS_CLK);
            i_gpio_sense <= 4'($random(seed));
            bus_read(`DAQ_CTRL_BASE);
            bus_read(`DAQ_CTRL_BASE + 1);
        end

        test_id <= 3;
        for (int i = 0; i < 10; i++) bus_write(QUIET_ADDR[i], 8'hFF);
        for (int i = 0; i < 10; i++) bus_read(QUIET_ADDR[i]);
        bus_read(`DAQ_CTRL_BASE);
        bus_read(`DAQ_CTRL_BASE + 1);
        bus_read(`DAQ_SYS_BASE + 4);

        test_id <= 4;
        @(negedge BUS_CLK);
        for (int k = 0; k < N; k++) push_words(k, 6);
        @(posedge BUS_CLK);
        i_arb_ready <= 1'b1;
        wait_drained(DRAIN_LIMIT);

        test_id <= 5;
        for (int c = 0; c < RANDOM_CYCLES; c++) begin
            @(posedge BUS_CLK);
            i_arb_ready <= ($random(seed) & 1) == 1;
            @(negedge BUS_CLK);
            for (int k = 0; k < N; k++) if (($random(seed) & 15) == 0) push_words(k, 1);
        end
        @(posedge BUS_CLK);
        i_arb_ready <= 1'b1;
        wait_drained(DRAIN_LIMIT);

        // Source 2 keeps the grant while it holds
        test_id <= 6;
        @(negedge BUS_CLK);
        for (int k = 0; k < N; k++) push_words(k, (k == 2) ? 12 : 3);
        @(posedge BUS_CLK);
        i_src_hold <= 6'b00_0100;
        repeat (10) @(posedge BUS_CLK);
        i_src_hold <= '0;
        wait_drained(DRAIN_LIMIT);

        $display("Error counts: checker %0d, assertions %0d, testbench %0d",
                 chk_errors, u_dut.u_assertions.assert_errors, tb_errors);
        if (chk_errors + u_dut.u_assertions.assert_errors + tb_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+logic
logic/daq_bus_pkg.sv
logic/daq_stream_pkg.sv
logic/bus_decoder.sv
logic/system_regs.sv
logic/control_gpio.sv
logic/rrp_arbiter.sv
logic/daq_core.sv
verif/daq_core_assertions.sv
verif/daq_core_checker.sv
verif/daq_core_tb.sv
